//--- core_pkg.sv
// Pipeline widths, reset vector, ALU operation and result-class encodings
package core_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // ALU operations
    localparam logic [3:0] ALU_ADD  = 4'b0000;
    localparam logic [3:0] ALU_SLL  = 4'b0001;
    localparam logic [3:0] ALU_SLT  = 4'b0010;
    localparam logic [3:0] ALU_SLTU = 4'b0011;
    localparam logic [3:0] ALU_XOR  = 4'b0100;
    localparam logic [3:0] ALU_SRL  = 4'b0101;
    localparam logic [3:0] ALU_OR   = 4'b0110;
    localparam logic [3:0] ALU_AND  = 4'b0111;
    localparam logic [3:0] ALU_SUB  = 4'b1000;
    localparam logic [3:0] ALU_SRA  = 4'b1001;
    localparam logic [3:0] ALU_BEQ  = 4'b1010;  // Compare codes only drive the branch flag
    localparam logic [3:0] ALU_BNE  = 4'b1011;
    localparam logic [3:0] ALU_BLT  = 4'b1100;
    localparam logic [3:0] ALU_BGE  = 4'b1101;
    localparam logic [3:0] ALU_BLTU = 4'b1110;
    localparam logic [3:0] ALU_BGEU = 4'b1111;

    // What execute writes back
    localparam logic [2:0] RES_ALU   = 3'd0;
    localparam logic [2:0] RES_LUI   = 3'd1;
    localparam logic [2:0] RES_AUIPC = 3'd2;
    localparam logic [2:0] RES_LINK  = 3'd3;  // PC plus four for JAL and JALR
    localparam logic [2:0] RES_NONE  = 3'd4;

endpackage

//--- decode_unit.sv
// Decode stage with control decode, immediate build and decode-to-execute register
module decode_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       id_valid,
    input  isa_pkg::instr_t            id_instr,
    input  logic [core_pkg::XLEN-1:0]   id_pc,
    output logic [core_pkg::REG_AW-1:0] rs1_addr,
    output logic [core_pkg::REG_AW-1:0] rs2_addr,
    input  logic [core_pkg::XLEN-1:0]   rs1_data,
    input  logic [core_pkg::XLEN-1:0]   rs2_data,
    output logic                       ex_valid,
    output logic [core_pkg::XLEN-1:0]   ex_pc,
    output logic [3:0]                 ex_alu_op,
    output logic [2:0]                 ex_res_class,
    output logic                       ex_use_imm,
    output logic [core_pkg::XLEN-1:0]   ex_imm,
    output logic [core_pkg::REG_AW-1:0] ex_rs1,
    output logic [core_pkg::REG_AW-1:0] ex_rs2,
    output logic [core_pkg::XLEN-1:0]   ex_rs1_data,
    output logic [core_pkg::XLEN-1:0]   ex_rs2_data,
    output logic [core_pkg::REG_AW-1:0] ex_rd,
    output logic                       ex_wen
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    logic [3:0]      alu_op;
    logic [2:0]      res_class;
    logic            use_imm;
    logic            wen;
    logic            alt;

    function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            F3_ADD:  return sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic logic [3:0] branch_op(input logic [2:0] f3);
        case (f3)
            F3_BEQ:  return ALU_BEQ;
            F3_BNE:  return ALU_BNE;
            F3_BLT:  return ALU_BLT;
            F3_BGE:  return ALU_BGE;
            F3_BLTU: return ALU_BLTU;
            F3_BGEU: return ALU_BGEU;
            default: return ALU_ADD;  // Reserved code never branches
        endcase
    endfunction

    assign rs1_addr = id_instr.r.rs1;
    assign rs2_addr = id_instr.r.rs2;
    assign alt      = id_instr.r.funct7[5];

    assign imm_i = {{20{id_instr.i.imm12[11]}}, id_instr.i.imm12};
    assign imm_b = {{20{id_instr.r.funct7[6]}}, id_instr.r.rd[0], id_instr.r.funct7[5:0],
                    id_instr.r.rd[4:1], 1'b0};
    assign imm_u = {id_instr.i.imm12, id_instr.i.rs1, id_instr.i.funct3, 12'b0};
    assign imm_j = {{12{id_instr.i.imm12[11]}}, id_instr.i.rs1, id_instr.i.funct3,
                    id_instr.i.imm12[0], id_instr.i.imm12[10:1], 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        res_class = RES_NONE;
        use_imm   = 1'b0;
        imm       = imm_i;
        wen       = 1'b0;
        case (id_instr.r.opcode)
            OPC_OP: begin
                alu_op    = arith_op(id_instr.r.funct3, alt);
                res_class = RES_ALU;
                wen       = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op    = arith_op(id_instr.r.funct3, alt && id_instr.r.funct3 == F3_SR);
                res_class = RES_ALU;
                use_imm   = 1'b1;
                wen       = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                res_class = (id_instr.r.opcode == OPC_LUI) ? RES_LUI : RES_AUIPC;
                imm       = imm_u;
                wen       = 1'b1;
            end
            OPC_JAL: begin
                res_class = RES_LINK;
                imm       = imm_j;
                wen       = 1'b1;
            end
            OPC_JALR: begin
                res_class = RES_LINK;
                use_imm   = 1'b1;  // ALU forms rs1 plus offset as the target
                wen       = 1'b1;
            end
            OPC_BRANCH: begin
                alu_op = branch_op(id_instr.r.funct3);
                imm    = imm_b;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wen   <= 1'b0;
        end else begin
            ex_valid <= id_valid && !flush;
            ex_wen   <= id_valid && !flush && wen && id_instr.r.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= id_pc;
        ex_alu_op    <= alu_op;
        ex_res_class <= res_class;
        ex_use_imm   <= use_imm;
        ex_imm       <= imm;
        ex_rs1       <= rs1_addr;
        ex_rs2       <= rs2_addr;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_rd        <= id_instr.r.rd;
    end

endmodule

//--- execute_unit.sv
// Execute stage with forwarding, ALU, branch resolve, redirect and write-back register
module execute_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ex_valid,
    input  logic [core_pkg::XLEN-1:0]   ex_pc,
    input  logic [3:0]                 ex_alu_op,
    input  logic [2:0]                 ex_res_class,
    input  logic                       ex_use_imm,
    input  logic [core_pkg::XLEN-1:0]   ex_imm,
    input  logic [core_pkg::REG_AW-1:0] ex_rs1,
    input  logic [core_pkg::REG_AW-1:0] ex_rs2,
    input  logic [core_pkg::XLEN-1:0]   ex_rs1_data,
    input  logic [core_pkg::XLEN-1:0]   ex_rs2_data,
    input  logic [core_pkg::REG_AW-1:0] ex_rd,
    input  logic                       ex_wen,
    output logic                       redirect,
    output logic [core_pkg::XLEN-1:0]   redirect_pc,
    output logic                       wb_valid,
    output logic [core_pkg::XLEN-1:0]   wb_pc,
    output logic                       wb_wen,
    output logic [core_pkg::REG_AW-1:0] wb_rd,
    output logic [core_pkg::XLEN-1:0]   wb_value
);
    import core_pkg::*;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] result;
    logic            cond;
    logic            is_link;

    // Instruction one ahead sits in the write-back register
    assign rs1_val = (wb_wen && wb_rd == ex_rs1) ? wb_value : ex_rs1_data;
    assign rs2_val = (wb_wen && wb_rd == ex_rs2) ? wb_value : ex_rs2_data;
    assign op_b    = ex_use_imm ? ex_imm : rs2_val;

    always_comb begin
        alu_result = '0;
        cond       = 1'b0;
        case (ex_alu_op)
            ALU_ADD:  alu_result = rs1_val + op_b;
            ALU_SUB:  alu_result = rs1_val - op_b;
            ALU_SLL:  alu_result = rs1_val << op_b[4:0];
            ALU_SLT:  alu_result = XLEN'($signed(rs1_val) < $signed(op_b));
            ALU_SLTU: alu_result = XLEN'(rs1_val < op_b);
            ALU_XOR:  alu_result = rs1_val ^ op_b;
            ALU_SRL:  alu_result = rs1_val >> op_b[4:0];
            ALU_SRA:  alu_result = $signed(rs1_val) >>> op_b[4:0];
            ALU_OR:   alu_result = rs1_val | op_b;
            ALU_AND:  alu_result = rs1_val & op_b;
            ALU_BEQ:  cond = rs1_val == op_b;
            ALU_BNE:  cond = rs1_val != op_b;
            ALU_BLT:  cond = $signed(rs1_val) < $signed(op_b);
            ALU_BGE:  cond = $signed(rs1_val) >= $signed(op_b);
            ALU_BLTU: cond = rs1_val < op_b;
            ALU_BGEU: cond = rs1_val >= op_b;
        endcase
    end

    assign is_link = ex_res_class == RES_LINK;
    assign pc_imm  = ex_pc + ex_imm;  // Branch, JAL and AUIPC share this adder

    // Taken transfer squashes the two younger stages
    assign redirect    = ex_valid && (cond || is_link);
    assign redirect_pc = (is_link && ex_use_imm) ? {alu_result[XLEN-1:1], 1'b0} : pc_imm;

    always_comb begin
        case (ex_res_class)
            RES_ALU:   result = alu_result;
            RES_LUI:   result = ex_imm;
            RES_AUIPC: result = pc_imm;
            RES_LINK:  result = ex_pc + XLEN'(4);
            default:   result = '0;  // Branches write nothing
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_wen   <= ex_wen;  // Already cleared for bubbles and x0
        end
    end

    always_ff @(posedge clk) begin
        wb_pc    <= ex_pc;
        wb_rd    <= ex_rd;
        wb_value <= result;
    end

endmodule

//--- fetch_unit.sv
// Fetch stage with program counter, next-PC select and fetch-to-decode register
module fetch_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     redirect,
    input  logic [core_pkg::XLEN-1:0] redirect_pc,
    output logic [core_pkg::XLEN-1:0] imem_addr,
    input  isa_pkg::instr_t          imem_data,
    output logic                     id_valid,
    output isa_pkg::instr_t          id_instr,
    output logic [core_pkg::XLEN-1:0] id_pc
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    assign pc_next   = redirect ? redirect_pc : pc + XLEN'(4);
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= RESET_PC;
            id_valid <= 1'b0;
        end else begin
            pc       <= pc_next;
            id_valid <= !redirect && imem_data != INSTR_BUBBLE;  // Zero word is a bubble
        end
    end

    always_ff @(posedge clk) begin
        id_instr <= redirect ? INSTR_BUBBLE : imem_data;  // Squash the wrong-path word
        id_pc    <= pc;
    end

endmodule

//--- isa_pkg.sv
// RV32I instruction word layout and the integer-subset encodings
package isa_pkg;

    // Register-register layout, also the S and B field positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate layout, upper bits shared with U and J
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Arithmetic function codes
    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB with bit 30
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch function codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam instr_t INSTR_BUBBLE = '0;  // All-zero word never retires

endpackage

//--- regfile.sv
// Integer register file, two read ports with write-through, one write port
module regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [core_pkg::REG_AW-1:0] rs1_addr,
    input  logic [core_pkg::REG_AW-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]   rs1_data,
    output logic [core_pkg::XLEN-1:0]   rs2_data,
    input  logic                       wen,
    input  logic [core_pkg::REG_AW-1:0] rd,
    input  logic [core_pkg::XLEN-1:0]   wdata
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[rd] <= wdata;  // Decode never enables x0
        end
    end

    // Same-cycle write is visible to decode
    assign rs1_data = (wen && rd == rs1_addr) ? wdata : regs[rs1_addr];
    assign rs2_data = (wen && rd == rs2_addr) ? wdata : regs[rs2_addr];

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_rv_core -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "Simulation result: passed" \
    || { echo "Simulation result: failed"; exit 1; }

//--- rv_core.sv
// Four-stage RV32I integer core top with instruction port and retire trace
module rv_core (
    input  logic                       clk,
    input  logic                       rst,
    output logic [core_pkg::XLEN-1:0]   imem_addr,
    input  isa_pkg::instr_t            imem_data,
    output logic                       retire_valid,
    output logic [core_pkg::XLEN-1:0]   retire_pc,
    output logic                       retire_wen,
    output logic [core_pkg::REG_AW-1:0] retire_rd,
    output logic [core_pkg::XLEN-1:0]   retire_value
);
    import core_pkg::*;
    import isa_pkg::*;

    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    logic              id_valid;
    instr_t            id_instr;
    logic [XLEN-1:0]   id_pc;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              ex_valid;
    logic [XLEN-1:0]   ex_pc;
    logic [3:0]        ex_alu_op;
    logic [2:0]        ex_res_class;
    logic              ex_use_imm;
    logic [XLEN-1:0]   ex_imm;
    logic [REG_AW-1:0] ex_rs1;
    logic [REG_AW-1:0] ex_rs2;
    logic [XLEN-1:0]   ex_rs1_data;
    logic [XLEN-1:0]   ex_rs2_data;
    logic [REG_AW-1:0] ex_rd;
    logic              ex_wen;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .id_valid    (id_valid),
        .id_instr    (id_instr),
        .id_pc       (id_pc)
    );

    decode_unit u_decode (
        .clk          (clk),
        .rst          (rst),
        .flush        (redirect),
        .id_valid     (id_valid),
        .id_instr     (id_instr),
        .id_pc        (id_pc),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_alu_op    (ex_alu_op),
        .ex_res_class (ex_res_class),
        .ex_use_imm   (ex_use_imm),
        .ex_imm       (ex_imm),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_rs1_data  (ex_rs1_data),
        .ex_rs2_data  (ex_rs2_data),
        .ex_rd        (ex_rd),
        .ex_wen       (ex_wen)
    );

    // Write-back register feeds both the write port and the retire trace
    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (retire_wen),
        .rd       (retire_rd),
        .wdata    (retire_value)
    );

    execute_unit u_execute (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_alu_op    (ex_alu_op),
        .ex_res_class (ex_res_class),
        .ex_use_imm   (ex_use_imm),
        .ex_imm       (ex_imm),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_rs1_data  (ex_rs1_data),
        .ex_rs2_data  (ex_rs2_data),
        .ex_rd        (ex_rd),
        .ex_wen       (ex_wen),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .wb_valid     (retire_valid),
        .wb_pc        (retire_pc),
        .wb_wen       (retire_wen),
        .wb_rd        (retire_rd),
        .wb_value     (retire_value)
    );

endmodule

//--- tb.f
isa_pkg.sv
core_pkg.sv
regfile.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
rv_core.sv
tb_rv_core_props.sv
tb_rv_core.sv

//--- tb_rv_core.sv
// Testbench for the RV32I core, random program checked against an instruction-level model
module tb_rv_core;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int PROG_WORDS  = 64;
    localparam int RETIRE_GOAL = 200;
    localparam int WAIT_LIMIT  = 40;

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   imem_addr;
    instr_t            imem_data;
    logic              retire_valid;
    logic [XLEN-1:0]   retire_pc;
    logic              retire_wen;
    logic [REG_AW-1:0] retire_rd;
    logic [XLEN-1:0]   retire_value;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc [RETIRE_GOAL];
    logic        exp_wen [RETIRE_GOAL];
    logic [4:0]  exp_rd [RETIRE_GOAL];
    logic [31:0] exp_value [RETIRE_GOAL];
    integer      seed;
    int          errors;
    int          checks;
    int          timeouts;
    int          retired;
    int          edges;
    bit          ok;

    rv_core u_rv_core (.*);

    bind rv_core tb_rv_core_props u_props (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Addresses past the program read as bubbles
    assign imem_data = (imem_addr < XLEN'(PROG_WORDS * 4)) ? prog[imem_addr[7:2]] : '0;

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // I layout, also R when the upper twelve bits are funct7 and rs2
    function automatic logic [31:0] pack_i(input logic [11:0] hi, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {hi, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            F3_ADD:  r = alt ? a - b : a + b;
            F3_SLL:  r = a << b[4:0];
            F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: r = {31'b0, a < b};
            F3_XOR:  r = a ^ b;
            F3_SR: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            F3_OR:   r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic make_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        int unsigned kind;
        int unsigned hop;
        for (int k = 0; k < PROG_WORDS - 1; k++) begin
            kind = (k == 0) ? 0 : pick(20);  // First word always retires
            rd   = 5'(pick(8));  // x0 to x7 keeps dependences dense
            rs1  = 5'(pick(8));
            rs2  = 5'(pick(8));
            f3   = 3'(pick(8));
            imm  = 12'($random(seed));
            hop  = 1 + pick((PROG_WORDS - 1 - k < 4) ? PROG_WORDS - 1 - k : 4);
            if (kind < 7) begin
                f7 = ((f3 == F3_ADD || f3 == F3_SR) && imm[10]) ? 7'h20 : 7'h00;
                prog[k] = pack_i({f7, rs2}, rs1, f3, rd, OPC_OP);
            end else if (kind < 12 || kind == 19) begin
                if (f3 == F3_SLL) begin
                    imm[11:5] = 7'h00;
                end
                if (f3 == F3_SR) begin
                    imm[11:5] = {1'b0, imm[10], 5'b0};  // SRLI or SRAI
                end
                prog[k] = pack_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end else if (kind < 14) begin
                prog[k] = {20'($random(seed)), rd, ((kind == 12) ? OPC_LUI : OPC_AUIPC)};
            end else if (kind < 16) begin
                f3 = 3'(pick(6));
                if (f3 > 3'd1) begin
                    f3 = f3 + 3'd2;  // Skip the two reserved codes
                end
                prog[k] = branch_word(13'(hop * 4), rs2, rs1, f3);
            end else if (kind == 16) begin
                prog[k] = jal_word(21'(hop * 4), rd);
            end else if (kind == 17) begin
                prog[k] = pack_i(12'((k + hop) * 4), 5'd0, 3'd0, rd, OPC_JALR);
            end else begin
                prog[k] = '0;
            end
        end
        prog[PROG_WORDS - 1] = jal_word(21'd0, 5'd0);  // Endless loop on itself
    endtask

    // Steps the program one instruction at a time and records each retire
    task automatic build_expected();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] val;
        logic        wr;
        int          n;
        pc = RESET_PC;
        n  = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        while (n < RETIRE_GOAL) begin
            w     = prog[pc[7:2]];
            a     = model_regs[w[19:15]];
            b     = model_regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            next  = pc + 32'd4;
            val   = '0;
            wr    = 1'b0;
            case (w[6:0])
                OPC_OP: begin
                    wr  = 1'b1;
                    val = arith(w[14:12], w[30], a, b);
                end
                OPC_OP_IMM: begin
                    wr  = 1'b1;
                    val = arith(w[14:12], w[30] && w[14:12] == F3_SR, a, imm_i);
                end
                OPC_LUI: begin
                    wr  = 1'b1;
                    val = {w[31:12], 12'b0};
                end
                OPC_AUIPC: begin
                    wr  = 1'b1;
                    val = pc + {w[31:12], 12'b0};
                end
                OPC_JAL: begin
                    wr   = 1'b1;
                    val  = pc + 32'd4;
                    next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                OPC_JALR: begin
                    wr   = 1'b1;
                    val  = pc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                OPC_BRANCH: begin
                    if (branch_taken(w[14:12], a, b)) begin
                        next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            if (w != '0) begin  // Zero word retires nothing
                exp_pc[n]    = pc;
                exp_wen[n]   = wr && w[11:7] != 5'd0;
                exp_rd[n]    = w[11:7];
                exp_value[n] = val;
                if (exp_wen[n]) begin
                    model_regs[w[11:7]] = val;
                end
                n++;
            end
            pc = next;
        end
    endtask

    task automatic check_field(input string name, input int idx, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error: %s at retire %0d expected %h actual %h", name, idx, expected,
                     actual);
        end
    endtask

    task automatic wait_retire(output bit found, output int cycles);
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            found = retire_valid;
        end
    endtask

    initial begin
        seed     = 34300;
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        retired  = 0;
        rst      = 1'b1;
        make_program();
        build_expected();
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            assert (!retire_valid) else begin
                errors++;
                $display("retire_valid was high while reset was held");
            end
        end
        rst = 1'b0;
        wait_retire(ok, edges);
        if (ok) begin
            check_field("first_retire_edge", 0, 32'd3, 32'(edges));  // Three stages deep
        end
        while (ok) begin
            check_field("retire_pc", retired, exp_pc[retired], retire_pc);
            check_field("retire_wen", retired, 32'(exp_wen[retired]), 32'(retire_wen));
            if (exp_wen[retired]) begin
                check_field("retire_rd", retired, 32'(exp_rd[retired]), 32'(retire_rd));
                check_field("retire_value", retired, exp_value[retired], retire_value);
            end
            retired++;
            if (retired == RETIRE_GOAL) begin
                break;
            end
            wait_retire(ok, edges);
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout after %0d retires, no further instruction retired", retired);
        end
        $display("Retired %0d, checks %0d, errors %0d, timeouts %0d, property failures %0d",
                 retired, checks, errors, timeouts, u_rv_core.u_props.fail_count);
        if (errors == 0 && timeouts == 0 && u_rv_core.u_props.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb_rv_core_props.sv
// Retire-port rules for the core, bound into the top level
module tb_rv_core_props (
    input logic                        clk,
    input logic                        rst,
    input logic                        retire_valid,
    input logic [core_pkg::XLEN-1:0]   retire_pc,
    input logic                        retire_wen,
    input logic [core_pkg::REG_AW-1:0] retire_rd
);
    int unsigned fail_count = 0;

    wen_needs_valid: assert property (
        @(posedge clk) disable iff (rst) retire_wen |-> retire_valid
    ) else begin
        fail_count++;
        $error("retire_wen high without retire_valid");
    end

    wen_needs_rd: assert property (
        @(posedge clk) disable iff (rst) retire_wen |-> retire_rd != '0
    ) else begin
        fail_count++;
        $error("retire_wen high with retire_rd zero");
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (rst) retire_valid |-> retire_pc[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("retire_pc not word aligned");
    end

    // Pipeline is empty one edge into reset
    quiet_in_reset: assert property (
        @(posedge clk) rst |=> !retire_valid
    ) else begin
        fail_count++;
        $error("instruction retired while rst was high");
    end

endmodule
